/* files.f */
source/lsu_pkg.sv
source/word_encdec.sv
source/lsu_ctrl.sv
source/data_ram.sv
source/lsu_top.sv
testbench/lsu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -j 0 \
   --top-module lsu_tb -f files.f --Mdir obj_dir -o lsu_sim

out="$(./obj_dir/lsu_sim 2>&1)" || true
echo "$out"

if grep -q -x "=== PASS ===" <<< "$out"; then
   echo "Simulation succeeded."
   exit 0
fi
echo "Simulation did not succeed."
exit 1

/* source/data_ram.sv */
`timescale 1ns/10ps

module data_ram #(
   parameter int DEPTH_WORDS = 1024
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               mem_req,
   input  lsu_pkg::mem_req_t  mem_cmd,
   output logic               mem_ack,
   output logic [31:0]        mem_rdata
);

   localparam int IDX_W = $clog2(DEPTH_WORDS);

   logic [31:0]      mem [DEPTH_WORDS];
   logic [IDX_W-1:0] idx;
   logic             fire;

   // Upper word address bits are dropped, so addresses alias.
   assign idx  = mem_cmd.word_addr[IDX_W-1:0];
   assign fire = mem_req && !mem_ack;          // New request, not yet acknowledged.

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_ack <= 1'b0;
      end else if (fire) begin
         mem_ack <= 1'b1;
      end else if (!mem_req) begin
         mem_ack <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fire && mem_cmd.write) begin
         for (int b = 0; b < 4; b++) begin
            if (mem_cmd.be[b]) begin
               mem[idx][b*8 +: 8] <= mem_cmd.wdata[b*8 +: 8];
            end
         end
      end
   end

   // Read word is held until the next read.
   always_ff @(posedge clk) begin
      if (fire && !mem_cmd.write) begin
         mem_rdata <= mem[idx];
      end
   end

endmodule

/* source/lsu_ctrl.sv */
`timescale 1ns/10ps

module lsu_ctrl (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                core_req,
   input  lsu_pkg::lsu_req_t   core_cmd,
   output logic                core_ack,
   output lsu_pkg::lsu_resp_t  core_resp,
   output logic                mem_req,
   output lsu_pkg::mem_req_t   mem_cmd,
   input  logic                mem_ack,
   input  logic [31:0]         mem_rdata
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_MEM_REQ,
      ST_MEM_REL,
      ST_RESP,
      ST_CORE_REL
   } state_t;

   state_t              state_q;
   lsu_pkg::lsu_req_t   cmd_q;
   lsu_pkg::lsu_resp_t  resp_q;
   logic                core_ack_q;
   logic                mem_req_q;
   logic                accept;
   logic [1:0]          offset;
   logic [31:0]         decode;
   logic                unaligned;
   logic [3:0]          writeb;

   assign accept = (state_q == ST_IDLE) && core_req;
   assign offset = cmd_q.addr[1:0];

   word_encdec u_encdec (
      .funct3    (cmd_q.funct3),
      .addr      (offset),
      .data      (mem_rdata),
      .write     (cmd_q.write),
      .decode    (decode),
      .unaligned (unaligned),
      .writeb    (writeb)
   );

   // Accepted command, held until the core side completes.
   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_q <= core_cmd;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q    <= ST_IDLE;
         core_ack_q <= 1'b0;
         mem_req_q  <= 1'b0;
         resp_q     <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (core_req) begin
                  state_q <= ST_MEM_REQ;
               end
            end

            // First cycle here decides; mem_req low means not yet issued.
            ST_MEM_REQ: begin
               if (!mem_req_q) begin
                  if (unaligned) begin
                     resp_q     <= '{rdata: 32'h0000_0000, fault: 1'b1};
                     core_ack_q <= 1'b1;
                     state_q    <= ST_RESP;
                  end else begin
                     mem_req_q <= 1'b1;
                  end
               end else if (mem_ack) begin
                  // Read data is valid while mem_ack is high.
                  resp_q     <= '{rdata: cmd_q.write ? 32'h0000_0000 : decode,
                                  fault: 1'b0};
                  core_ack_q <= 1'b1;
                  mem_req_q  <= 1'b0;
                  state_q    <= ST_MEM_REL;
               end
            end

            ST_MEM_REL: begin
               if (!mem_ack) begin
                  state_q <= ST_RESP;                 // Memory side is idle again.
               end
            end

            ST_RESP: begin
               if (!core_req) begin
                  core_ack_q <= 1'b0;
                  state_q    <= ST_CORE_REL;
               end
            end

            ST_CORE_REL: begin
               resp_q  <= '0;                         // Quiet bus between requests.
               state_q <= ST_IDLE;
            end

            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   assign core_ack  = core_ack_q;
   assign core_resp = resp_q;
   assign mem_req   = mem_req_q;

   // Store lanes follow the byte offset; loads carry an empty mask.
   assign mem_cmd.write     = cmd_q.write;
   assign mem_cmd.word_addr = cmd_q.addr[31:2];
   assign mem_cmd.be        = writeb << offset;
   assign mem_cmd.wdata     = cmd_q.wdata << {offset, 3'b000};

endmodule

/* source/lsu_pkg.sv */
package lsu_pkg;

   // Width codes, matched against funct3[1:0]. Code 2'b11 is reserved.
   localparam logic [1:0] ENCDEC_BYTE = 2'b00;
   localparam logic [1:0] ENCDEC_HALF = 2'b01;
   localparam logic [1:0] ENCDEC_WORD = 2'b10;

   // Core side request, 68 bits.
   typedef struct packed {
      logic        write;     // Store when set.
      logic [2:0]  funct3;    // Bit 2 selects zero extension.
      logic [31:0] addr;      // Byte address.
      logic [31:0] wdata;     // Store data, right aligned.
   } lsu_req_t;

   // Core side response.
   typedef struct packed {
      logic [31:0] rdata;     // Extended load data, zero on stores and faults.
      logic        fault;     // Misaligned or reserved width.
   } lsu_resp_t;

   // Memory side request, one word with byte lanes.
   typedef struct packed {
      logic        write;
      logic [29:0] word_addr;
      logic [3:0]  be;        // Lane enables, bit 0 is the low byte.
      logic [31:0] wdata;     // Already moved to its lanes.
   } mem_req_t;

endpackage

/* source/lsu_top.sv */
`timescale 1ns/10ps

module lsu_top #(
   parameter int DEPTH_WORDS = 1024
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                core_req,
   input  lsu_pkg::lsu_req_t   core_cmd,
   output logic                core_ack,
   output lsu_pkg::lsu_resp_t  core_resp
);

   logic               mem_req;
   lsu_pkg::mem_req_t  mem_cmd;
   logic               mem_ack;
   logic [31:0]        mem_rdata;

   lsu_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .core_req  (core_req),
      .core_cmd  (core_cmd),
      .core_ack  (core_ack),
      .core_resp (core_resp),
      .mem_req   (mem_req),
      .mem_cmd   (mem_cmd),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

   data_ram #(
      .DEPTH_WORDS (DEPTH_WORDS)
   ) u_ram (
      .clk       (clk),
      .rst_n     (rst_n),
      .mem_req   (mem_req),
      .mem_cmd   (mem_cmd),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

endmodule

/* source/word_encdec.sv */
`timescale 1ns/10ps

module word_encdec (
   input  logic [2:0]  funct3,
   input  logic [1:0]  addr,
   input  logic [31:0] data,
   input  logic        write,
   output logic [31:0] decode,
   output logic        unaligned,
   output logic [3:0]  writeb
);

   logic [1:0]  width;
   logic        zero_ext;
   logic        is_byte;
   logic        is_half;
   logic        is_word;
   logic [7:0]  byte_sel;
   logic [15:0] half_sel;

   assign width    = funct3[1:0];
   assign zero_ext = funct3[2];
   assign is_byte  = (width == lsu_pkg::ENCDEC_BYTE);
   assign is_half  = (width == lsu_pkg::ENCDEC_HALF);
   assign is_word  = (width == lsu_pkg::ENCDEC_WORD);

   always_comb begin
      case (addr)
         2'b00:   byte_sel = data[7:0];
         2'b01:   byte_sel = data[15:8];
         2'b10:   byte_sel = data[23:16];
         default: byte_sel = data[31:24];
      endcase
   end

   // A halfword may start at any lane but the last.
   always_comb begin
      case (addr)
         2'b00:   half_sel = data[15:0];
         2'b01:   half_sel = data[23:8];
         2'b10:   half_sel = data[31:16];
         default: half_sel = 16'h0000;
      endcase
   end

   always_comb begin
      decode    = 32'h0000_0000;
      unaligned = 1'b0;
      if (is_byte) begin
         decode = {{24{~zero_ext & byte_sel[7]}}, byte_sel};
      end else if (is_half) begin
         if (addr == 2'b11) begin
            unaligned = 1'b1;
         end else begin
            decode = {{16{~zero_ext & half_sel[15]}}, half_sel};
         end
      end else if (is_word) begin
         if (addr != 2'b00) begin
            unaligned = 1'b1;
         end else begin
            decode = data;
         end
      end else begin
         unaligned = 1'b1;                        // Reserved width code.
      end
   end

   // Mask for offset 0; the caller shifts it into place.
   assign writeb[0] = write;
   assign writeb[1] = write & (is_half | is_word);
   assign writeb[2] = write & is_word;
   assign writeb[3] = write & is_word;

endmodule

/* testbench/lsu_tb.sv */
`timescale 1ns/10ps

module lsu_tb;

   localparam int DEPTH_WORDS = 64;                   // Small RAM so random addresses alias.
   localparam int CLK_NS      = 8;
   localparam int N_LANE_OPS  = 25;
   localparam int N_FAULT_OPS = 12;
   localparam int N_RANDOM    = 400;
   localparam int N_OPS       = 2 * DEPTH_WORDS + N_LANE_OPS + N_FAULT_OPS + N_RANDOM;
   localparam int WATCHDOG_NS = (N_OPS * 20 + 10) * CLK_NS;

   logic                clk;
   logic                rst_n;
   logic                core_req;
   lsu_pkg::lsu_req_t   core_cmd;
   logic                core_ack;
   lsu_pkg::lsu_resp_t  core_resp;

   logic [7:0]          ref_mem [DEPTH_WORDS*4];   // Byte image of the RAM.
   lsu_pkg::lsu_resp_t  exp_q [$];
   logic [31:0]         lfsr_state;
   logic [7:0]          byte_vals [4] = '{8'h81, 8'h7e, 8'hc3, 8'h3c};
   logic [15:0]         half_vals [3] = '{16'h8001, 16'h7ffe, 16'hf00d};

   lsu_top #(
      .DEPTH_WORDS (DEPTH_WORDS)
   ) i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .core_req  (core_req),
      .core_cmd  (core_cmd),
      .core_ack  (core_ack),
      .core_resp (core_resp)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_NS / 2) clk = ~clk;
      end
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic check_resp(input string name, input lsu_pkg::lsu_resp_t got,
                             input lsu_pkg::lsu_resp_t exp);
      if (got !== exp) begin
         report_failure($sformatf("Mismatch at %0t: %s got rdata=%h fault=%b, %s", $time, name,
                                  got.rdata, got.fault,
                                  $sformatf("expected rdata=%h fault=%b", exp.rdata, exp.fault)));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("Mismatch at %0t: %s got %b, expected %b",
                                  $time, name, got, exp));
      end
   endtask

   // Galois form with taps for x^32 + x^22 + x^2 + x + 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic lsu_pkg::lsu_req_t make_cmd(input logic write, input logic [2:0] funct3,
                                                  input logic [31:0] addr,
                                                  input logic [31:0] wdata);
      lsu_pkg::lsu_req_t c;
      c.write  = write;
      c.funct3 = funct3;
      c.addr   = addr;
      c.wdata  = wdata;
      return c;
   endfunction

   // Expected response; stores update the byte image.
   function automatic lsu_pkg::lsu_resp_t ref_access(input lsu_pkg::lsu_req_t c);
      logic [1:0]         width;
      logic [1:0]         off;
      logic [29:0]        word;
      logic [31:0]        base;
      logic [31:0]        val;
      logic               fault;
      int                 nbytes;
      lsu_pkg::lsu_resp_t r;
      width  = c.funct3[1:0];
      off    = c.addr[1:0];
      nbytes = (width == lsu_pkg::ENCDEC_BYTE) ? 1 : (width == lsu_pkg::ENCDEC_HALF) ? 2 : 4;
      fault  = (width == 2'b11) || (width == lsu_pkg::ENCDEC_HALF && off == 2'b11) ||
               (width == lsu_pkg::ENCDEC_WORD && off != 2'b00);
      word   = c.addr[31:2] % 30'(DEPTH_WORDS);
      base   = {word, off};
      val    = '0;
      r      = '0;
      r.fault = fault;
      if (!fault && c.write) begin
         for (int k = 0; k < nbytes; k++) begin
            ref_mem[base + 32'(k)] = c.wdata[k*8 +: 8];
         end
      end else if (!fault) begin
         for (int k = 0; k < nbytes; k++) begin
            val[k*8 +: 8] = ref_mem[base + 32'(k)];
         end
         if (nbytes == 1 && !c.funct3[2] && val[7]) begin
            val[31:8] = '1;
         end
         if (nbytes == 2 && !c.funct3[2] && val[15]) begin
            val[31:16] = '1;
         end
         r.rdata = val;
      end
      return r;
   endfunction

   // One four-phase transfer; hold keeps core_req up after core_ack.
   task automatic run_access(input lsu_pkg::lsu_req_t c, input int hold);
      exp_q.push_back(ref_access(c));
      @(posedge clk);
      #1;
      core_cmd = c;
      core_req = 1'b1;
      do begin
         @(posedge clk);
         #1;
      end while (!core_ack);
      for (int i = 0; i < hold; i++) begin
         @(posedge clk);
         #1;
         check_bit("core_ack", core_ack, 1'b1);
      end
      core_req = 1'b0;
      do begin
         @(posedge clk);
         #1;
      end while (core_ack);
   endtask

   // Compares each response on core_ack rise and while it is held.
   initial begin : monitor
      logic               prev_ack;
      lsu_pkg::lsu_resp_t held;
      prev_ack = 1'b0;
      held     = '0;
      forever begin
         @(posedge clk);
         #1;
         if (!rst_n) begin
            prev_ack = 1'b0;
         end else begin
            if (core_ack && !prev_ack) begin
               if (exp_q.size() == 0) begin
                  report_failure("core_ack rose while no request was outstanding.");
               end else begin
                  held = exp_q.pop_front();
                  check_resp("core_resp", core_resp, held);
               end
            end else if (core_ack) begin
               check_resp("core_resp (held)", core_resp, held);
            end
            prev_ack = core_ack;
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      report_failure($sformatf("Timeout after %0d ns: the run hung.", WATCHDOG_NS));
   end

   initial begin : stimulus
      lsu_pkg::lsu_req_t c;
      logic [31:0]       base;
      logic [31:0]       addr;
      logic [31:0]       r;
      logic [3:0]        hi;
      logic [7:0]        idx;
      logic [1:0]        off;
      logic [2:0]        funct3;
      logic              write;
      core_req   = 1'b0;
      core_cmd   = '0;
      rst_n      = 1'b0;
      lfsr_state = 32'h627a;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;

      repeat (3) begin
         check_bit("core_ack", core_ack, 1'b0);
         check_resp("core_resp", core_resp, '0);
         @(posedge clk);
         #1;
      end

      // Fill every word, then read all back.
      for (int w = 0; w < DEPTH_WORDS; w++) begin
         addr = 32'(w) << 2;
         run_access(make_cmd(1'b1, {1'b0, lsu_pkg::ENCDEC_WORD}, addr,
                             addr * 32'h9e37_79b1 + 32'h0f0f_0f0f), 0);
      end
      for (int w = 0; w < DEPTH_WORDS; w++) begin
         run_access(make_cmd(1'b0, {1'b0, lsu_pkg::ENCDEC_WORD}, 32'(w) << 2, '0), 0);
      end

      base = 32'h0000_0014;
      for (int o = 0; o < 4; o++) begin
         run_access(make_cmd(1'b1, {1'b0, lsu_pkg::ENCDEC_BYTE}, base + 32'(o),
                             {24'h5a5a5a, byte_vals[o]}), 0);
      end
      run_access(make_cmd(1'b0, {1'b0, lsu_pkg::ENCDEC_WORD}, base, '0), 1);
      for (int o = 0; o < 4; o++) begin
         run_access(make_cmd(1'b0, {1'b0, lsu_pkg::ENCDEC_BYTE}, base + 32'(o), '0), 0);
         run_access(make_cmd(1'b0, {1'b1, lsu_pkg::ENCDEC_BYTE}, base + 32'(o), '0), 0);
      end
      for (int o = 0; o < 3; o++) begin
         run_access(make_cmd(1'b1, {1'b0, lsu_pkg::ENCDEC_HALF}, base + 32'(o),
                             {16'hbeef, half_vals[o]}), 0);
         run_access(make_cmd(1'b0, {1'b0, lsu_pkg::ENCDEC_WORD}, base, '0), 0);
      end
      for (int o = 0; o < 3; o++) begin
         run_access(make_cmd(1'b0, {1'b0, lsu_pkg::ENCDEC_HALF}, base + 32'(o), '0), 0);
         run_access(make_cmd(1'b0, {1'b1, lsu_pkg::ENCDEC_HALF}, base + 32'(o), '0), 0);
      end

      // Faulting requests must leave memory untouched.
      base = 32'h0000_0024;
      run_access(make_cmd(1'b0, {1'b0, lsu_pkg::ENCDEC_HALF}, base + 32'd3, '0), 0);
      run_access(make_cmd(1'b0, {1'b1, lsu_pkg::ENCDEC_HALF}, base + 32'd3, '0), 0);
      run_access(make_cmd(1'b1, {1'b0, lsu_pkg::ENCDEC_HALF}, base + 32'd3, 32'hffff_ffff), 0);
      for (int o = 1; o < 4; o++) begin
         run_access(make_cmd(1'b0, {1'b0, lsu_pkg::ENCDEC_WORD}, base + 32'(o), '0), 0);
         run_access(make_cmd(1'b1, {1'b0, lsu_pkg::ENCDEC_WORD}, base + 32'(o), 32'hdead_beef), 0);
      end
      run_access(make_cmd(1'b0, 3'b011, base, '0), 0);
      run_access(make_cmd(1'b1, 3'b011, base, 32'h1234_5678), 1);
      run_access(make_cmd(1'b0, {1'b0, lsu_pkg::ENCDEC_WORD}, base, '0), 0);

      for (int n = 0; n < N_RANDOM; n++) begin
         r      = rand_bits(1);
         write  = r[0];
         r      = rand_bits(3);
         funct3 = r[2:0];
         r      = rand_bits(4);
         hi     = r[3:0];
         r      = rand_bits(8);
         idx    = r[7:0];                             // Up to 256 words alias onto the RAM.
         r      = rand_bits(2);
         off    = r[1:0];
         c      = make_cmd(write, funct3, {hi, 18'h00000, idx, off}, rand_bits(32));
         r      = rand_bits(2);
         run_access(c, int'(r[1:0]));
      end

      $display("=== PASS ===");
      $finish;
   end

endmodule
